/* design/ex_defs.svh */
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// Data path width
`define EX_WORD_SIZE 32

// PC and memory address width
`define EX_ADDR_SIZE 32

// Register file index width
`define EX_REG_SIZE 5

`endif

/* design/ex_isa_pkg.sv */
package ex_isa_pkg;

    // Operation carried down to the execute stage
    typedef enum logic [4:0] {
        ADD  = 5'd0,
        SUB  = 5'd1,
        SLL  = 5'd2,
        SLT  = 5'd3,
        SLTU = 5'd4,
        XOR  = 5'd5,
        SRL  = 5'd6,
        SRA  = 5'd7,
        OR   = 5'd8,
        AND  = 5'd9,
        // Conditional branches
        BEQ  = 5'd10,
        BNE  = 5'd11,
        BLT  = 5'd12,
        BGE  = 5'd13,
        BLTU = 5'd14,
        BGEU = 5'd15,
        // Unconditional jumps
        JAL  = 5'd16,
        JALR = 5'd17
    } alu_opcode_e;

    // Memory access width for loads and stores
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memop_size_e;

endpackage : ex_isa_pkg

/* design/ex_pipe_pkg.sv */
`include "ex_defs.svh"

package ex_pipe_pkg;

    // Decoded instruction handed from decode to execute
    typedef struct packed {
        ex_isa_pkg::alu_opcode_e   alu_opcode;
        logic [`EX_WORD_SIZE-1:0]  alu_src_a;
        logic [`EX_WORD_SIZE-1:0]  alu_src_b;
        logic [`EX_WORD_SIZE-1:0]  br_src_a;
        logic [`EX_WORD_SIZE-1:0]  br_src_b;
        logic [`EX_ADDR_SIZE-1:0]  pc;
        logic                      rf_we;
        logic [`EX_REG_SIZE-1:0]   rf_waddr;
        logic [`EX_WORD_SIZE-1:0]  rf_st_data;
        ex_isa_pkg::memop_size_e   memop_size;
        logic                      memop_rd;
        logic                      memop_wr;
        logic                      memop_sign_ext;
        logic                      is_jump;
        logic                      valid;
        logic                      finish_test;
    } id_ex_t;

    // Results and control passed on to the memory stage
    typedef struct packed {
        logic [`EX_WORD_SIZE-1:0]  alu_res;
        logic                      rf_we;
        logic [`EX_REG_SIZE-1:0]   rf_waddr;
        logic [`EX_WORD_SIZE-1:0]  st_data;
        logic [3:0]                st_be;
        ex_isa_pkg::memop_size_e   memop_size;
        logic                      memop_rd;
        logic                      memop_wr;
        logic                      memop_sign_ext;
        logic                      is_jump;
        logic [`EX_ADDR_SIZE-1:0]  seq_pc;
        logic                      valid;
        logic                      finish_test;
    } ex_mem_t;

    // Redirect request towards fetch
    typedef struct packed {
        logic                      taken;
        logic [`EX_ADDR_SIZE-1:0]  target;
    } branch_t;

endpackage : ex_pipe_pkg

/* design/ex_alu.sv */
`timescale 1ns/1ps

`include "ex_defs.svh"

module ex_alu (
    input  ex_isa_pkg::alu_opcode_e  opcode_i,
    input  logic [`EX_WORD_SIZE-1:0] src_a_i,
    input  logic [`EX_WORD_SIZE-1:0] src_b_i,
    output logic [`EX_WORD_SIZE-1:0] res_o
);

    logic [`EX_WORD_SIZE-1:0] sum;
    logic [`EX_WORD_SIZE-1:0] diff;
    logic [4:0]               shamt;
    logic                     lt_signed;
    logic                     lt_unsigned;

    assign sum   = src_a_i + src_b_i;
    assign diff  = src_a_i - src_b_i;
    // Only the low five bits count for a 32-bit shift
    assign shamt = src_b_i[4:0];

    assign lt_signed   = $signed(src_a_i) < $signed(src_b_i);
    assign lt_unsigned = src_a_i < src_b_i;

    always_comb begin
        case (opcode_i)
            ex_isa_pkg::ADD: res_o = sum;
            ex_isa_pkg::SUB: res_o = diff;
            ex_isa_pkg::SLL: res_o = src_a_i << shamt;
            ex_isa_pkg::SLT: res_o = {{(`EX_WORD_SIZE-1){1'b0}}, lt_signed};
            ex_isa_pkg::SLTU: res_o = {{(`EX_WORD_SIZE-1){1'b0}}, lt_unsigned};
            ex_isa_pkg::XOR: res_o = src_a_i ^ src_b_i;
            ex_isa_pkg::SRL: res_o = src_a_i >> shamt;
            ex_isa_pkg::SRA: res_o = $unsigned($signed(src_a_i) >>> shamt);
            ex_isa_pkg::OR: res_o = src_a_i | src_b_i;
            ex_isa_pkg::AND: res_o = src_a_i & src_b_i;
            // Branch and JAL target is pc plus offset
            ex_isa_pkg::BEQ,
            ex_isa_pkg::BNE,
            ex_isa_pkg::BLT,
            ex_isa_pkg::BGE,
            ex_isa_pkg::BLTU,
            ex_isa_pkg::BGEU,
            ex_isa_pkg::JAL: res_o = sum;
            // JALR target is forced to an even address
            ex_isa_pkg::JALR: res_o = {sum[`EX_WORD_SIZE-1:1], 1'b0};
            default: res_o = sum;
        endcase
    end

endmodule : ex_alu

/* design/ex_branch_cmp.sv */
`timescale 1ns/1ps

`include "ex_defs.svh"

module ex_branch_cmp (
    input  ex_isa_pkg::alu_opcode_e  opcode_i,
    input  logic [`EX_WORD_SIZE-1:0] src_a_i,
    input  logic [`EX_WORD_SIZE-1:0] src_b_i,
    output logic                     taken_o
);

    logic equal;
    logic lt_signed;
    logic lt_unsigned;

    assign equal       = src_a_i == src_b_i;
    assign lt_signed   = $signed(src_a_i) < $signed(src_b_i);
    assign lt_unsigned = src_a_i < src_b_i;

    always_comb begin
        case (opcode_i)
            ex_isa_pkg::BEQ:  taken_o = equal;
            ex_isa_pkg::BNE:  taken_o = !equal;
            ex_isa_pkg::BLT:  taken_o = lt_signed;
            ex_isa_pkg::BGE:  taken_o = !lt_signed;
            ex_isa_pkg::BLTU: taken_o = lt_unsigned;
            ex_isa_pkg::BGEU: taken_o = !lt_unsigned;
            // Jumps always redirect
            ex_isa_pkg::JAL,
            ex_isa_pkg::JALR: taken_o = 1'b1;
            default:          taken_o = 1'b0;
        endcase
    end

endmodule : ex_branch_cmp

/* design/ex_store_align.sv */
`timescale 1ns/1ps

`include "ex_defs.svh"

module ex_store_align (
    input  ex_isa_pkg::memop_size_e  size_i,
    input  logic [1:0]               addr_lo_i,
    input  logic [`EX_WORD_SIZE-1:0] data_i,
    output logic [3:0]               be_o,
    output logic [`EX_WORD_SIZE-1:0] data_o
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    assign byte_lane = data_i[7:0];
    assign half_lane = data_i[15:0];

    always_comb begin
        case (size_i)
            ex_isa_pkg::BYTE: begin
                // One lane picked by the byte offset
                be_o   = 4'b0001 << addr_lo_i;
                data_o = {4{byte_lane}};
            end
            ex_isa_pkg::HALF: begin
                // Upper or lower half by address bit 1
                be_o   = addr_lo_i[1] ? 4'b1100 : 4'b0011;
                data_o = {2{half_lane}};
            end
            ex_isa_pkg::WORD: begin
                be_o   = 4'b1111;
                data_o = data_i;
            end
            default: begin
                be_o   = 4'b1111;
                data_o = data_i;
            end
        endcase
    end

endmodule : ex_store_align

/* design/ex_stage.sv */
`timescale 1ns/1ps

`include "ex_defs.svh"

module ex_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  ex_pipe_pkg::id_ex_t   id_ex_i,
    input  logic                  block_ex_i,
    input  logic                  inject_nops_i,
    output ex_pipe_pkg::ex_mem_t  ex_mem_o,
    output ex_pipe_pkg::branch_t  branch_o
);

    ex_pipe_pkg::id_ex_t      id_ex_d;
    ex_pipe_pkg::id_ex_t      id_ex_q;
    logic [`EX_ADDR_SIZE-1:0] seq_pc_q;

    logic [`EX_WORD_SIZE-1:0] alu_res;
    logic                     cmp_taken;
    logic [3:0]               st_be;
    logic [`EX_WORD_SIZE-1:0] st_data;
    logic                     is_link;

    // NOP injection kills the control bits and keeps the payload
    always_comb begin
        id_ex_d = id_ex_i;
        if (inject_nops_i) begin
            id_ex_d.rf_we       = 1'b0;
            id_ex_d.memop_rd    = 1'b0;
            id_ex_d.memop_wr    = 1'b0;
            id_ex_d.is_jump     = 1'b0;
            id_ex_d.valid       = 1'b0;
            id_ex_d.finish_test = 1'b0;
        end
    end

    // ID/EX decoupling register, block holds everything
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_q.rf_we       <= 1'b0;
            id_ex_q.memop_rd    <= 1'b0;
            id_ex_q.memop_wr    <= 1'b0;
            id_ex_q.is_jump     <= 1'b0;
            id_ex_q.valid       <= 1'b0;
            id_ex_q.finish_test <= 1'b0;
        end else if (!block_ex_i) begin
            id_ex_q  <= id_ex_d;
            seq_pc_q <= id_ex_i.pc + `EX_ADDR_SIZE'd4;
        end
    end

    ex_alu u_alu (
        .opcode_i (id_ex_q.alu_opcode),
        .src_a_i  (id_ex_q.alu_src_a),
        .src_b_i  (id_ex_q.alu_src_b),
        .res_o    (alu_res)
    );

    ex_branch_cmp u_branch_cmp (
        .opcode_i (id_ex_q.alu_opcode),
        .src_a_i  (id_ex_q.br_src_a),
        .src_b_i  (id_ex_q.br_src_b),
        .taken_o  (cmp_taken)
    );

    // The ALU result doubles as the store address
    ex_store_align u_store_align (
        .size_i    (id_ex_q.memop_size),
        .addr_lo_i (alu_res[1:0]),
        .data_i    (id_ex_q.rf_st_data),
        .be_o      (st_be),
        .data_o    (st_data)
    );

    // Jumps write back the return address
    assign is_link = (id_ex_q.alu_opcode == ex_isa_pkg::JAL) ||
                     (id_ex_q.alu_opcode == ex_isa_pkg::JALR);

    always_comb begin
        ex_mem_o.alu_res        = is_link ? seq_pc_q : alu_res;
        ex_mem_o.rf_we          = id_ex_q.rf_we;
        ex_mem_o.rf_waddr       = id_ex_q.rf_waddr;
        ex_mem_o.st_data        = st_data;
        ex_mem_o.st_be          = st_be;
        ex_mem_o.memop_size     = id_ex_q.memop_size;
        ex_mem_o.memop_rd       = id_ex_q.memop_rd;
        ex_mem_o.memop_wr       = id_ex_q.memop_wr;
        ex_mem_o.memop_sign_ext = id_ex_q.memop_sign_ext;
        ex_mem_o.is_jump        = id_ex_q.is_jump;
        ex_mem_o.seq_pc         = seq_pc_q;
        ex_mem_o.valid          = id_ex_q.valid;
        ex_mem_o.finish_test    = id_ex_q.finish_test;
    end

    // Opcode is not reset, so a bubble must never redirect fetch
    assign branch_o.taken  = cmp_taken & id_ex_q.valid;
    assign branch_o.target = alu_res;

endmodule : ex_stage

/* verification/ex_stage_vectors.svh */
`ifndef EX_STAGE_VECTORS_SVH
`define EX_STAGE_VECTORS_SVH

// Columns: name, opcode, block, inject
//          alu_src_a, alu_src_b, br_src_a, br_src_b, pc, store size, store data
//          expected alu_res, taken, target, st_be, st_data, seq_pc, valid

    task automatic load_vectors();
        // Arithmetic and logic
        add_vec("add", ex_isa_pkg::ADD, 0, 0,
                32'h00000005, 32'h00000007, 32'h0, 32'h0, 32'h00000100, sz_w, 32'h0,
                32'h0000000c, 0, 32'h0000000c, 4'hf, 32'h0, 32'h00000104, 1);
        add_vec("sub", ex_isa_pkg::SUB, 0, 0,
                32'h00000003, 32'h00000005, 32'h0, 32'h0, 32'h00000104, sz_w, 32'h0,
                32'hfffffffe, 0, 32'hfffffffe, 4'hf, 32'h0, 32'h00000108, 1);
        // Shift amount 36 wraps to 4
        add_vec("sll", ex_isa_pkg::SLL, 0, 0,
                32'h00000003, 32'h00000024, 32'h0, 32'h0, 32'h00000108, sz_w, 32'h0,
                32'h00000030, 0, 32'h00000030, 4'hf, 32'h0, 32'h0000010c, 1);
        add_vec("slt", ex_isa_pkg::SLT, 0, 0,
                32'hffffffff, 32'h00000001, 32'h0, 32'h0, 32'h0000010c, sz_w, 32'h0,
                32'h00000001, 0, 32'h00000001, 4'hf, 32'h0, 32'h00000110, 1);
        add_vec("sltu", ex_isa_pkg::SLTU, 0, 0,
                32'hffffffff, 32'h00000001, 32'h0, 32'h0, 32'h00000110, sz_w, 32'h0,
                32'h00000000, 0, 32'h00000000, 4'hf, 32'h0, 32'h00000114, 1);
        add_vec("xor", ex_isa_pkg::XOR, 0, 0,
                32'hf0f0f0f0, 32'hff00ff00, 32'h0, 32'h0, 32'h00000114, sz_w, 32'h0,
                32'h0ff00ff0, 0, 32'h0ff00ff0, 4'hf, 32'h0, 32'h00000118, 1);
        add_vec("srl", ex_isa_pkg::SRL, 0, 0,
                32'h80000000, 32'h00000004, 32'h0, 32'h0, 32'h00000118, sz_w, 32'h0,
                32'h08000000, 0, 32'h08000000, 4'hf, 32'h0, 32'h0000011c, 1);
        add_vec("sra", ex_isa_pkg::SRA, 0, 0,
                32'h80000000, 32'h00000004, 32'h0, 32'h0, 32'h0000011c, sz_w, 32'h0,
                32'hf8000000, 0, 32'hf8000000, 4'hf, 32'h0, 32'h00000120, 1);
        add_vec("or", ex_isa_pkg::OR, 0, 0,
                32'h12340000, 32'h00005678, 32'h0, 32'h0, 32'h00000120, sz_w, 32'h0,
                32'h12345678, 0, 32'h12345678, 4'hf, 32'h0, 32'h00000124, 1);
        add_vec("and", ex_isa_pkg::AND, 0, 0,
                32'hff00ff00, 32'h0f0f0f0f, 32'h0, 32'h0, 32'h00000124, sz_w, 32'h0,
                32'h0f000f00, 0, 32'h0f000f00, 4'hf, 32'h0, 32'h00000128, 1);
        // Branches, target is pc plus offset
        add_vec("beq_taken", ex_isa_pkg::BEQ, 0, 0,
                32'h00000200, 32'h00000010, 32'h5, 32'h5, 32'h00000200, sz_w, 32'h0,
                32'h00000210, 1, 32'h00000210, 4'hf, 32'h0, 32'h00000204, 1);
        add_vec("beq_not", ex_isa_pkg::BEQ, 0, 0,
                32'h00000204, 32'h00000020, 32'h5, 32'h6, 32'h00000204, sz_w, 32'h0,
                32'h00000224, 0, 32'h00000224, 4'hf, 32'h0, 32'h00000208, 1);
        add_vec("bne_taken", ex_isa_pkg::BNE, 0, 0,
                32'h00000208, 32'h00000008, 32'h5, 32'h6, 32'h00000208, sz_w, 32'h0,
                32'h00000210, 1, 32'h00000210, 4'hf, 32'h0, 32'h0000020c, 1);
        add_vec("bne_not", ex_isa_pkg::BNE, 0, 0,
                32'h0000020c, 32'hfffffffc, 32'h7, 32'h7, 32'h0000020c, sz_w, 32'h0,
                32'h00000208, 0, 32'h00000208, 4'hf, 32'h0, 32'h00000210, 1);
        add_vec("blt_taken", ex_isa_pkg::BLT, 0, 0,
                32'h00000210, 32'h00000040, 32'hffffffff, 32'h1, 32'h00000210, sz_w, 32'h0,
                32'h00000250, 1, 32'h00000250, 4'hf, 32'h0, 32'h00000214, 1);
        add_vec("blt_not", ex_isa_pkg::BLT, 0, 0,
                32'h00000214, 32'h00000040, 32'h1, 32'hffffffff, 32'h00000214, sz_w, 32'h0,
                32'h00000254, 0, 32'h00000254, 4'hf, 32'h0, 32'h00000218, 1);
        add_vec("bge_taken", ex_isa_pkg::BGE, 0, 0,
                32'h00000218, 32'h00000008, 32'h1, 32'hffffffff, 32'h00000218, sz_w, 32'h0,
                32'h00000220, 1, 32'h00000220, 4'hf, 32'h0, 32'h0000021c, 1);
        add_vec("bge_not", ex_isa_pkg::BGE, 0, 0,
                32'h0000021c, 32'h00000008, 32'hffffffff, 32'h1, 32'h0000021c, sz_w, 32'h0,
                32'h00000224, 0, 32'h00000224, 4'hf, 32'h0, 32'h00000220, 1);
        add_vec("bltu_taken", ex_isa_pkg::BLTU, 0, 0,
                32'h00000220, 32'h00000010, 32'h1, 32'hffffffff, 32'h00000220, sz_w, 32'h0,
                32'h00000230, 1, 32'h00000230, 4'hf, 32'h0, 32'h00000224, 1);
        add_vec("bltu_not", ex_isa_pkg::BLTU, 0, 0,
                32'h00000224, 32'h00000010, 32'hffffffff, 32'h1, 32'h00000224, sz_w, 32'h0,
                32'h00000234, 0, 32'h00000234, 4'hf, 32'h0, 32'h00000228, 1);
        add_vec("bgeu_taken", ex_isa_pkg::BGEU, 0, 0,
                32'h00000228, 32'h00000004, 32'hffffffff, 32'h1, 32'h00000228, sz_w, 32'h0,
                32'h0000022c, 1, 32'h0000022c, 4'hf, 32'h0, 32'h0000022c, 1);
        add_vec("bgeu_not", ex_isa_pkg::BGEU, 0, 0,
                32'h0000022c, 32'h00000004, 32'h1, 32'hffffffff, 32'h0000022c, sz_w, 32'h0,
                32'h00000230, 0, 32'h00000230, 4'hf, 32'h0, 32'h00000230, 1);
        // Jumps link with pc plus 4
        add_vec("jal", ex_isa_pkg::JAL, 0, 0,
                32'h00000300, 32'h00000100, 32'h0, 32'h0, 32'h00000300, sz_w, 32'h0,
                32'h00000304, 1, 32'h00000400, 4'hf, 32'h0, 32'h00000304, 1);
        add_vec("jalr", ex_isa_pkg::JALR, 0, 0,
                32'h00001001, 32'h00000004, 32'h0, 32'h0, 32'h00000304, sz_w, 32'h0,
                32'h00000308, 1, 32'h00001004, 4'hf, 32'h0, 32'h00000308, 1);
        // Stores at every legal offset
        add_vec("sb_off0", ex_isa_pkg::ADD, 0, 0,
                32'h00001000, 32'h0, 32'h0, 32'h0, 32'h00000400, sz_b, 32'ha1b2c3d4,
                32'h00001000, 0, 32'h00001000, 4'h1, 32'hd4d4d4d4, 32'h00000404, 1);
        add_vec("sb_off1", ex_isa_pkg::ADD, 0, 0,
                32'h00001000, 32'h1, 32'h0, 32'h0, 32'h00000404, sz_b, 32'ha1b2c3d4,
                32'h00001001, 0, 32'h00001001, 4'h2, 32'hd4d4d4d4, 32'h00000408, 1);
        add_vec("sb_off2", ex_isa_pkg::ADD, 0, 0,
                32'h00001000, 32'h2, 32'h0, 32'h0, 32'h00000408, sz_b, 32'ha1b2c3d4,
                32'h00001002, 0, 32'h00001002, 4'h4, 32'hd4d4d4d4, 32'h0000040c, 1);
        add_vec("sb_off3", ex_isa_pkg::ADD, 0, 0,
                32'h00001000, 32'h3, 32'h0, 32'h0, 32'h0000040c, sz_b, 32'ha1b2c3d4,
                32'h00001003, 0, 32'h00001003, 4'h8, 32'hd4d4d4d4, 32'h00000410, 1);
        add_vec("sh_off0", ex_isa_pkg::ADD, 0, 0,
                32'h00001000, 32'h0, 32'h0, 32'h0, 32'h00000410, sz_h, 32'ha1b2c3d4,
                32'h00001000, 0, 32'h00001000, 4'h3, 32'hc3d4c3d4, 32'h00000414, 1);
        add_vec("sh_off2", ex_isa_pkg::ADD, 0, 0,
                32'h00001000, 32'h2, 32'h0, 32'h0, 32'h00000414, sz_h, 32'ha1b2c3d4,
                32'h00001002, 0, 32'h00001002, 4'hc, 32'hc3d4c3d4, 32'h00000418, 1);
        add_vec("sw_off0", ex_isa_pkg::ADD, 0, 0,
                32'h00001000, 32'h0, 32'h0, 32'h0, 32'h00000418, sz_w, 32'ha1b2c3d4,
                32'h00001000, 0, 32'h00001000, 4'hf, 32'ha1b2c3d4, 32'h0000041c, 1);
        // Hold and bubble control
        add_vec("block", ex_isa_pkg::ADD, 1, 0,
                32'h11111111, 32'h22222222, 32'h0, 32'h0, 32'h00000500, sz_b, 32'h55555555,
                32'h00001000, 0, 32'h00001000, 4'hf, 32'ha1b2c3d4, 32'h0000041c, 1);
        add_vec("block_inject", ex_isa_pkg::ADD, 1, 1,
                32'h00000009, 32'h00000009, 32'h0, 32'h0, 32'h00000600, sz_h, 32'h0,
                32'h00001000, 0, 32'h00001000, 4'hf, 32'ha1b2c3d4, 32'h0000041c, 1);
        // Compare is true here but the bubble must not redirect
        add_vec("inject", ex_isa_pkg::BEQ, 0, 1,
                32'h00000504, 32'h00000010, 32'h3, 32'h3, 32'h00000504, sz_w, 32'h0,
                32'h00000514, 0, 32'h00000514, 4'hf, 32'h0, 32'h00000508, 0);
        add_vec("after_inject", ex_isa_pkg::ADD, 0, 0,
                32'h00000001, 32'h00000002, 32'h0, 32'h0, 32'h00000508, sz_w, 32'h0,
                32'h00000003, 0, 32'h00000003, 4'hf, 32'h0, 32'h0000050c, 1);
    endtask

`endif

/* verification/ex_stage_tb.sv */
`timescale 1ns/1ps

`include "ex_defs.svh"

module ex_stage_tb;

    localparam int edge_timeout_ns = 1000;

    localparam ex_isa_pkg::memop_size_e sz_b = ex_isa_pkg::BYTE;
    localparam ex_isa_pkg::memop_size_e sz_h = ex_isa_pkg::HALF;
    localparam ex_isa_pkg::memop_size_e sz_w = ex_isa_pkg::WORD;

    typedef struct packed {
        ex_pipe_pkg::id_ex_t       id_ex;
        logic                      block;
        logic                      inject;
        logic [`EX_WORD_SIZE-1:0]  exp_res;
        logic                      exp_taken;
        logic [`EX_ADDR_SIZE-1:0]  exp_target;
        logic [3:0]                exp_be;
        logic [`EX_WORD_SIZE-1:0]  exp_st_data;
        logic [`EX_ADDR_SIZE-1:0]  exp_seq_pc;
        logic                      exp_valid;
    } vector_t;

    bit                    clk;
    logic                  rst_n;
    ex_pipe_pkg::id_ex_t   id_ex;
    logic                  block_ex;
    logic                  inject_nops;
    ex_pipe_pkg::ex_mem_t  ex_mem;
    ex_pipe_pkg::branch_t  branch;

    vector_t vectors[$];
    string   names[$];
    integer  seed;
    int      negedge_count = 0;
    int      tests_run = 0;
    int      tests_failed = 0;
    int      test_errors = 0;
    bit      timed_out = 1'b0;

    // Last entry captured by the ID/EX register
    ex_pipe_pkg::id_ex_t held_id_ex;

    ex_stage UUT (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .id_ex_i       (id_ex),
        .block_ex_i    (block_ex),
        .inject_nops_i (inject_nops),
        .ex_mem_o      (ex_mem),
        .branch_o      (branch)
    );

    initial begin
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(negedge clk) begin
        negedge_count++;
    end

    // Live vectors raise every control bit and spread the payload over the pc
    function automatic ex_pipe_pkg::id_ex_t make_id_ex(
        input ex_isa_pkg::alu_opcode_e op,
        input logic [`EX_WORD_SIZE-1:0] a, b, ba, bb,
        input logic [`EX_ADDR_SIZE-1:0] pc,
        input ex_isa_pkg::memop_size_e size,
        input logic [`EX_WORD_SIZE-1:0] sdata
    );
        ex_pipe_pkg::id_ex_t d;
        d = '0;
        d.alu_opcode     = op;
        d.alu_src_a      = a;
        d.alu_src_b      = b;
        d.br_src_a       = ba;
        d.br_src_b       = bb;
        d.pc             = pc;
        d.rf_we          = 1'b1;
        d.rf_waddr       = pc[6:2];
        d.rf_st_data     = sdata;
        d.memop_size     = size;
        d.memop_rd       = 1'b1;
        d.memop_wr       = 1'b1;
        d.memop_sign_ext = pc[3];
        d.is_jump        = 1'b1;
        d.valid          = 1'b1;
        d.finish_test    = 1'b1;
        return d;
    endfunction

    task automatic add_vec(
        input string name,
        input ex_isa_pkg::alu_opcode_e op,
        input logic block, inject,
        input logic [`EX_WORD_SIZE-1:0] a, b, ba, bb,
        input logic [`EX_ADDR_SIZE-1:0] pc,
        input ex_isa_pkg::memop_size_e size,
        input logic [`EX_WORD_SIZE-1:0] sdata, e_res,
        input logic e_taken,
        input logic [`EX_ADDR_SIZE-1:0] e_target,
        input logic [3:0] e_be,
        input logic [`EX_WORD_SIZE-1:0] e_st_data,
        input logic [`EX_ADDR_SIZE-1:0] e_seq_pc,
        input logic e_valid
    );
        vector_t v;
        v.id_ex       = make_id_ex(op, a, b, ba, bb, pc, size, sdata);
        v.block       = block;
        v.inject      = inject;
        v.exp_res     = e_res;
        v.exp_taken   = e_taken;
        v.exp_target  = e_target;
        v.exp_be      = e_be;
        v.exp_st_data = e_st_data;
        v.exp_seq_pc  = e_seq_pc;
        v.exp_valid   = e_valid;
        vectors.push_back(v);
        names.push_back(name);
    endtask

    `include "ex_stage_vectors.svh"

    task automatic check_value(input string test, input string field,
                               input logic [`EX_WORD_SIZE-1:0] expected,
                               input logic [`EX_WORD_SIZE-1:0] actual);
        if (actual !== expected) begin
            $display("mismatch in %s: %s expected %h, actual %h",
                     test, field, expected, actual);
            test_errors++;
        end
    endtask

    task automatic wait_negedge();
        int start;
        int waited;
        start  = negedge_count;
        waited = 0;
        while (negedge_count == start && waited < edge_timeout_ns) begin
            #1;
            waited++;
        end
        if (negedge_count == start) begin
            $display("timeout: no falling clock edge seen within %0d ns", edge_timeout_ns);
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s FAILED with %0d mismatches", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic inspect_reset_state();
        check_value("reset_state", "valid", 32'd0, 32'(ex_mem.valid));
        check_value("reset_state", "rf_we", 32'd0, 32'(ex_mem.rf_we));
        check_value("reset_state", "memop_rd", 32'd0, 32'(ex_mem.memop_rd));
        check_value("reset_state", "memop_wr", 32'd0, 32'(ex_mem.memop_wr));
        check_value("reset_state", "is_jump", 32'd0, 32'(ex_mem.is_jump));
        check_value("reset_state", "finish_test", 32'd0, 32'(ex_mem.finish_test));
        check_value("reset_state", "taken", 32'd0, 32'(branch.taken));
        report_test("reset_state");
    endtask

    // Control bits of a live vector follow valid and the payload follows the held entry
    task automatic score_vector(input string name, input vector_t v,
                                input ex_pipe_pkg::id_ex_t held);
        check_value(name, "alu_res", v.exp_res, ex_mem.alu_res);
        check_value(name, "taken", 32'(v.exp_taken), 32'(branch.taken));
        check_value(name, "target", v.exp_target, branch.target);
        check_value(name, "st_be", 32'(v.exp_be), 32'(ex_mem.st_be));
        check_value(name, "st_data", v.exp_st_data, ex_mem.st_data);
        check_value(name, "seq_pc", v.exp_seq_pc, ex_mem.seq_pc);
        check_value(name, "valid", 32'(v.exp_valid), 32'(ex_mem.valid));
        check_value(name, "rf_we", 32'(v.exp_valid), 32'(ex_mem.rf_we));
        check_value(name, "memop_rd", 32'(v.exp_valid), 32'(ex_mem.memop_rd));
        check_value(name, "memop_wr", 32'(v.exp_valid), 32'(ex_mem.memop_wr));
        check_value(name, "is_jump", 32'(v.exp_valid), 32'(ex_mem.is_jump));
        check_value(name, "finish_test", 32'(v.exp_valid), 32'(ex_mem.finish_test));
        check_value(name, "rf_waddr", 32'(held.rf_waddr), 32'(ex_mem.rf_waddr));
        check_value(name, "memop_size", 32'(held.memop_size), 32'(ex_mem.memop_size));
        check_value(name, "memop_sign_ext", 32'(held.memop_sign_ext),
                    32'(ex_mem.memop_sign_ext));
    endtask

    function automatic logic [`EX_WORD_SIZE-1:0] model_arith(
        input ex_isa_pkg::alu_opcode_e op,
        input logic [`EX_WORD_SIZE-1:0] a, b
    );
        case (op)
            ex_isa_pkg::ADD: return a + b;
            ex_isa_pkg::SUB: return a - b;
            default:         return a ^ b;
        endcase
    endfunction

    task automatic run_random();
        logic [`EX_WORD_SIZE-1:0] a;
        logic [`EX_WORD_SIZE-1:0] b;
        logic [31:0]              pick;
        ex_isa_pkg::alu_opcode_e  op;
        string                    name;
        for (int k = 0; k < 32 && !timed_out; k++) begin
            a    = $random(seed);
            b    = $random(seed);
            pick = $random(seed);
            case (pick % 32'd3)
                32'd0:   op = ex_isa_pkg::ADD;
                32'd1:   op = ex_isa_pkg::SUB;
                default: op = ex_isa_pkg::XOR;
            endcase
            name        = $sformatf("random_%0d", k);
            id_ex       = make_id_ex(op, a, b, 32'h0, 32'h0, 32'h00000800, sz_w, 32'h0);
            block_ex    = 1'b0;
            inject_nops = 1'b0;
            wait_negedge();
            if (!timed_out) begin
                check_value(name, "alu_res", model_arith(op, a, b), ex_mem.alu_res);
                check_value(name, "target", model_arith(op, a, b), branch.target);
                check_value(name, "seq_pc", 32'h00000804, ex_mem.seq_pc);
                check_value(name, "taken", 32'd0, 32'(branch.taken));
                check_value(name, "valid", 32'd1, 32'(ex_mem.valid));
                report_test(name);
            end
        end
    endtask

    initial begin
        seed        = 32'h146cfaa6;
        rst_n       = 1'b0;
        id_ex       = '0;
        block_ex    = 1'b0;
        inject_nops = 1'b0;
        held_id_ex  = '0;
        load_vectors();

        // Reset held for 16 cycles and released on a falling edge
        for (int i = 0; i < 16 && !timed_out; i++) begin
            wait_negedge();
        end
        rst_n = 1'b1;
        if (!timed_out) begin
            inspect_reset_state();
        end

        for (int i = 0; i < vectors.size() && !timed_out; i++) begin
            id_ex       = vectors[i].id_ex;
            block_ex    = vectors[i].block;
            inject_nops = vectors[i].inject;
            if (!vectors[i].block) begin
                held_id_ex = vectors[i].id_ex;
            end
            wait_negedge();
            if (!timed_out) begin
                score_vector(names[i], vectors[i], held_id_ex);
                report_test(names[i]);
            end
        end

        run_random();

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (timed_out || tests_failed != 0) begin
            $display("Simulation failed");
        end else begin
            $display("Simulation completed successfully");
        end
        $finish;
    end

endmodule : ex_stage_tb

/* sim.f */
+incdir+design
+incdir+verification
design/ex_isa_pkg.sv
design/ex_pipe_pkg.sv
design/ex_alu.sv
design/ex_branch_cmp.sv
design/ex_store_align.sv
design/ex_stage.sv
verification/ex_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the execute stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module ex_stage_tb -f sim.f \
    -Mdir obj_dir -o ex_stage_sim \
    || { echo "Verilator build did not complete"; exit 1; }

out="$(./obj_dir/ex_stage_sim)"
echo "$out"

echo "$out" | grep -qx "Simulation completed successfully" && exit 0 || exit 1
